//--- hw/cache_geom_pkg.sv
package cache_geom_pkg;

  // Cache organisation
  localparam int ways       = 4;
  localparam int sets       = 16;
  localparam int index_bits = $clog2(sets);
  localparam int way_bits   = $clog2(ways);
  localparam int addr_bits  = 32;
  localparam int line_bits  = 256;

  // Line states, stable and transient
  // isad/isd wait for our own GetS and then its data
  // srd/ird wait for our own snoop data to appear on the response bus
  typedef enum logic [2:0] {
    st_i,
    st_isad,
    st_isd,
    st_s,
    st_e,
    st_srd,
    st_ird
  } line_state_e;

  // One state per way, read view of a single set
  typedef line_state_e [ways-1:0] set_states_t;

  typedef logic [ways-1:0]     way_vec_t;
  typedef logic [way_bits-1:0] way_idx_t;

  // Single state write, way is one-hot
  typedef struct packed {
    logic                  valid;
    logic [index_bits-1:0] index;
    way_vec_t              way;
    line_state_e           state;
  } state_wr_t;

endpackage

//--- hw/coh_bus_pkg.sv
package coh_bus_pkg;

  // Caches on the bus, the value itself addresses memory
  localparam int num_cache = 4;

  typedef logic [$clog2(num_cache+1)-1:0] cache_id_t;

  // Request bus opcodes
  typedef enum logic [1:0] {
    op_none,
    op_gets,
    op_getm
  } bus_op_e;

  // Response bus data kinds
  typedef enum logic {
    rk_data,
    rk_exclusive
  } resp_kind_e;

  typedef struct packed {
    logic                                valid;
    cache_id_t                           source;
    logic [cache_geom_pkg::addr_bits-1:0] addr;
    bus_op_e                             bus_op;
  } req_msg_t;

  typedef struct packed {
    logic                                 valid;
    cache_id_t                            source;
    cache_geom_pkg::way_idx_t             way;
    cache_id_t                            destination;
    logic                                 memory_flag;
    logic [cache_geom_pkg::addr_bits-1:0] addr;
    logic [cache_geom_pkg::line_bits-1:0] data;
    resp_kind_e                           kind;
  } resp_msg_t;

  typedef struct packed {
    logic                                 read;
    logic [cache_geom_pkg::addr_bits-1:0] addr;
  } cpu_req_t;

  // Way vectors from the tag lookup, each one-hot or zero
  typedef struct packed {
    cache_geom_pkg::way_vec_t cache_hit;
    cache_geom_pkg::way_vec_t bus_hit;
    cache_geom_pkg::way_vec_t evict;
  } way_hits_t;

endpackage

//--- hw/miss_requester.sv
`timescale 1ns/10ps

module miss_requester #(
  parameter int cache_id = 0
) (
  input  logic                        clk,
  input  logic                        rst,
  input  coh_bus_pkg::cpu_req_t       cpu,
  input  coh_bus_pkg::way_hits_t      hits,
  input  cache_geom_pkg::set_states_t cpu_states,
  input  logic                        req_bus_gnt,
  output cache_geom_pkg::state_wr_t   cpu_wr,
  output logic                        req_bus_req,
  output coh_bus_pkg::req_msg_t       req_bus_tx,
  output logic                        dfp_resp
);

  import cache_geom_pkg::*;
  import coh_bus_pkg::*;

  logic                 evict_free;
  logic                 hit_valid;
  logic                 miss_go;
  logic                 req_q;
  logic [addr_bits-1:0] addr_q;

  // Victim way free for a fill, or a readable hit
  always_comb begin
    evict_free = 1'b0;
    hit_valid  = 1'b0;
    for (int w = 0; w < ways; w++) begin
      if (hits.evict[w] && cpu_states[w] == st_i) begin
        evict_free = 1'b1;
      end
      if (hits.cache_hit[w] && (cpu_states[w] == st_s || cpu_states[w] == st_e)) begin
        hit_valid = 1'b1;
      end
    end
  end

  // Only one GetS outstanding at a time
  assign miss_go  = cpu.read && evict_free && !req_q;
  assign dfp_resp = cpu.read && hit_valid;

  always_comb begin
    cpu_wr.valid = miss_go;
    cpu_wr.index = cpu.addr[index_bits-1:0];
    cpu_wr.way   = hits.evict;
    cpu_wr.state = st_isad;
  end

  // Request held until the arbiter grants it
  always_ff @(posedge clk) begin
    if (rst) begin
      req_q <= 1'b0;
    end else if (miss_go) begin
      req_q <= 1'b1;
    end else if (req_q && req_bus_gnt) begin
      req_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (miss_go) begin
      addr_q <= cpu.addr;
    end
  end

  assign req_bus_req = req_q;

  always_comb begin
    req_bus_tx.valid  = req_q;
    req_bus_tx.source = cache_id_t'(cache_id);
    req_bus_tx.addr   = addr_q;
    req_bus_tx.bus_op = req_q ? op_gets : op_none;
  end

endmodule

//--- hw/line_state_store.sv
`timescale 1ns/10ps

module line_state_store (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [cache_geom_pkg::index_bits-1:0] cpu_index,
  input  logic [cache_geom_pkg::index_bits-1:0] req_index,
  input  logic [cache_geom_pkg::index_bits-1:0] resp_index,
  input  cache_geom_pkg::state_wr_t             cpu_wr,
  input  cache_geom_pkg::state_wr_t             snoop_wr,
  input  logic                                  invalidate_req,
  input  cache_geom_pkg::way_vec_t              inval_way,
  output cache_geom_pkg::set_states_t           cpu_states,
  output cache_geom_pkg::set_states_t           req_states,
  output cache_geom_pkg::set_states_t           resp_states,
  output logic                                  invalidate_resp
);

  import cache_geom_pkg::*;

  set_states_t state_q [sets];
  logic        inval_req_q;
  logic        inval_hit;

  // Three independent read ports
  assign cpu_states  = state_q[cpu_index];
  assign req_states  = state_q[req_index];
  assign resp_states = state_q[resp_index];

  // Later assignments win, so the order sets the write priority
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < sets; s++) begin
        for (int w = 0; w < ways; w++) begin
          state_q[s][w] <= st_i;
        end
      end
    end else begin
      for (int w = 0; w < ways; w++) begin
        if (cpu_wr.valid && cpu_wr.way[w]) begin
          state_q[cpu_wr.index][w] <= cpu_wr.state;
        end
        if (snoop_wr.valid && snoop_wr.way[w]) begin
          state_q[snoop_wr.index][w] <= snoop_wr.state;
        end
        // Back invalidation from the outer level beats both
        if (invalidate_req && inval_way[w]) begin
          state_q[cpu_index][w] <= st_i;
        end
      end
    end
  end

  // Acknowledge only the first cycle of a request that hits
  assign inval_hit = invalidate_req && (|inval_way) && !inval_req_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      inval_req_q     <= 1'b0;
      invalidate_resp <= 1'b0;
    end else begin
      inval_req_q     <= invalidate_req;
      invalidate_resp <= inval_hit;
    end
  end

endmodule

//--- hw/snoop_controller.sv
`timescale 1ns/10ps

module snoop_controller #(
  parameter int cache_id = 0
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  coh_bus_pkg::req_msg_t                req_bus_msg,
  input  coh_bus_pkg::resp_msg_t               resp_bus_msg,
  input  coh_bus_pkg::way_hits_t               hits,
  input  cache_geom_pkg::set_states_t          req_states,
  input  cache_geom_pkg::set_states_t          resp_states,
  input  logic [cache_geom_pkg::line_bits-1:0] bus_rdata,
  output cache_geom_pkg::state_wr_t            snoop_wr,
  output logic                                 req_bus_busy,
  output logic                                 resp_bus_req,
  output coh_bus_pkg::resp_msg_t               resp_bus_tx,
  output logic [cache_geom_pkg::line_bits-1:0] dfp_rdata
);

  import cache_geom_pkg::*;
  import coh_bus_pkg::*;

  logic                 own_req;
  logic                 own_resp;
  logic                 busy_q;
  logic                 busy_d;
  logic                 resp_req_q;
  logic                 resp_req_d;

  // Snoop data capture for the response bus
  logic                 send;
  logic                 send_flag;
  way_idx_t             send_way;
  way_idx_t             way_q;
  cache_id_t            dest_q;
  logic                 flag_q;
  logic [addr_bits-1:0] addr_q;
  logic [line_bits-1:0] data_q;

  assign own_req  = req_bus_msg.source == cache_id_t'(cache_id);
  assign own_resp = resp_bus_msg.source == cache_id_t'(cache_id);

  always_comb begin
    snoop_wr   = '0;
    busy_d     = busy_q;
    resp_req_d = resp_req_q;
    send       = 1'b0;
    send_flag  = 1'b0;
    send_way   = '0;
    dfp_rdata  = '0;

    // Request bus first, response bus only in a quiet cycle
    if (req_bus_msg.valid) begin
      snoop_wr.index = req_bus_msg.addr[index_bits-1:0];
      for (int w = 0; w < ways; w++) begin
        case (req_states[w])
          st_isad: begin
            // Our GetS won the bus, now wait for data
            if (own_req && req_bus_msg.bus_op == op_gets && hits.evict[w]) begin
              snoop_wr.valid  = 1'b1;
              snoop_wr.way[w] = 1'b1;
              snoop_wr.state  = st_isd;
              busy_d          = 1'b1;
            end
          end
          st_s: begin
            if (!own_req && req_bus_msg.bus_op == op_getm && hits.bus_hit[w]) begin
              snoop_wr.valid  = 1'b1;
              snoop_wr.way[w] = 1'b1;
              snoop_wr.state  = st_i;
            end
          end
          st_e: begin
            // Exclusive owner supplies the line
            if (!own_req && hits.bus_hit[w] &&
                (req_bus_msg.bus_op == op_gets || req_bus_msg.bus_op == op_getm)) begin
              snoop_wr.valid  = 1'b1;
              snoop_wr.way[w] = 1'b1;
              snoop_wr.state  = (req_bus_msg.bus_op == op_gets) ? st_srd : st_ird;
              send            = 1'b1;
              send_flag       = req_bus_msg.bus_op == op_gets;
              send_way        = way_idx_t'(w);
              resp_req_d      = 1'b1;
            end
          end
          default: begin
          end
        endcase
      end
    end else if (resp_bus_msg.valid) begin
      snoop_wr.index = resp_bus_msg.addr[index_bits-1:0];
      for (int w = 0; w < ways; w++) begin
        case (resp_states[w])
          st_isd: begin
            // Fill for our outstanding GetS
            if (resp_bus_msg.destination == cache_id_t'(cache_id) && hits.evict[w]) begin
              snoop_wr.valid  = 1'b1;
              snoop_wr.way[w] = 1'b1;
              snoop_wr.state  = (resp_bus_msg.kind == rk_exclusive) ? st_e : st_s;
              busy_d          = 1'b0;
              dfp_rdata       = resp_bus_msg.data;
            end
          end
          st_srd, st_ird: begin
            // Our own snoop data went out
            if (own_resp && resp_bus_msg.way == way_idx_t'(w)) begin
              snoop_wr.valid  = 1'b1;
              snoop_wr.way[w] = 1'b1;
              snoop_wr.state  = (resp_states[w] == st_srd) ? st_s : st_i;
              resp_req_d      = 1'b0;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q     <= 1'b0;
      resp_req_q <= 1'b0;
    end else begin
      busy_q     <= busy_d;
      resp_req_q <= resp_req_d;
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      way_q  <= send_way;
      dest_q <= req_bus_msg.source;
      flag_q <= send_flag;
      addr_q <= req_bus_msg.addr;
      data_q <= bus_rdata;
    end
  end

  assign req_bus_busy = busy_q;
  assign resp_bus_req = resp_req_q;

  always_comb begin
    resp_bus_tx.valid       = resp_req_q;
    resp_bus_tx.source      = cache_id_t'(cache_id);
    resp_bus_tx.way         = way_q;
    resp_bus_tx.destination = dest_q;
    resp_bus_tx.memory_flag = flag_q;
    resp_bus_tx.addr        = addr_q;
    resp_bus_tx.data        = data_q;
    resp_bus_tx.kind        = rk_data;
  end

endmodule

//--- hw/icache_coherence.sv
`timescale 1ns/10ps

module icache_coherence #(
  parameter int cache_id = 0
) (
  input  logic                                 clk,
  input  logic                                 rst,
  // CPU side
  input  coh_bus_pkg::cpu_req_t                cpu,
  input  coh_bus_pkg::way_hits_t               hits,
  output logic                                 dfp_resp,
  output logic [cache_geom_pkg::line_bits-1:0] dfp_rdata,
  input  logic [cache_geom_pkg::line_bits-1:0] bus_rdata,
  // Request bus
  input  coh_bus_pkg::req_msg_t                req_bus_msg,
  output coh_bus_pkg::req_msg_t                req_bus_tx,
  input  logic                                 req_bus_gnt,
  output logic                                 req_bus_req,
  output logic                                 req_bus_busy,
  // Response bus
  input  coh_bus_pkg::resp_msg_t               resp_bus_msg,
  output coh_bus_pkg::resp_msg_t               resp_bus_tx,
  input  logic                                 resp_bus_gnt,
  output logic                                 resp_bus_req,
  // Inclusive outer level
  input  logic                                 invalidate_req,
  output logic                                 invalidate_resp
);

  import cache_geom_pkg::*;

  set_states_t cpu_states;
  set_states_t req_states;
  set_states_t resp_states;
  state_wr_t   cpu_wr;
  state_wr_t   snoop_wr;

  miss_requester #(
    .cache_id (cache_id)
  ) i_miss_requester (
    .clk         (clk),
    .rst         (rst),
    .cpu         (cpu),
    .hits        (hits),
    .cpu_states  (cpu_states),
    .req_bus_gnt (req_bus_gnt),
    .cpu_wr      (cpu_wr),
    .req_bus_req (req_bus_req),
    .req_bus_tx  (req_bus_tx),
    .dfp_resp    (dfp_resp)
  );

  line_state_store i_line_state_store (
    .clk             (clk),
    .rst             (rst),
    .cpu_index       (cpu.addr[index_bits-1:0]),
    .req_index       (req_bus_msg.addr[index_bits-1:0]),
    .resp_index      (resp_bus_msg.addr[index_bits-1:0]),
    .cpu_wr          (cpu_wr),
    .snoop_wr        (snoop_wr),
    .invalidate_req  (invalidate_req),
    .inval_way       (hits.cache_hit),
    .cpu_states      (cpu_states),
    .req_states      (req_states),
    .resp_states     (resp_states),
    .invalidate_resp (invalidate_resp)
  );

  snoop_controller #(
    .cache_id (cache_id)
  ) i_snoop_controller (
    .clk          (clk),
    .rst          (rst),
    .req_bus_msg  (req_bus_msg),
    .resp_bus_msg (resp_bus_msg),
    .hits         (hits),
    .req_states   (req_states),
    .resp_states  (resp_states),
    .bus_rdata    (bus_rdata),
    .snoop_wr     (snoop_wr),
    .req_bus_busy (req_bus_busy),
    .resp_bus_req (resp_bus_req),
    .resp_bus_tx  (resp_bus_tx),
    .dfp_rdata    (dfp_rdata)
  );

endmodule

//--- tb/icache_coherence_asserts.sv
`timescale 1ns/10ps

module icache_coherence_asserts (
  input logic clk,
  input logic rst,
  input logic req_bus_req,
  input logic req_bus_gnt,
  input logic invalidate_resp
);

  // GetS request only withdrawn after the arbiter granted it
  req_held_until_gnt: assert property (
    @(posedge clk) disable iff (rst) $fell(req_bus_req) |-> $past(req_bus_gnt)
  ) else $error("req_bus_req dropped without a grant in the cycle before");

  // Back invalidation acknowledge is a single-cycle pulse
  inval_resp_pulse: assert property (
    @(posedge clk) disable iff (rst) invalidate_resp |=> !invalidate_resp
  ) else $error("invalidate_resp held for more than one cycle");

endmodule

bind icache_coherence icache_coherence_asserts i_icache_coherence_asserts (
  .clk             (clk),
  .rst             (rst),
  .req_bus_req     (req_bus_req),
  .req_bus_gnt     (req_bus_gnt),
  .invalidate_resp (invalidate_resp)
);

//--- tb/tb_top.sv
`timescale 1ns/10ps

module tb_top;

  import cache_geom_pkg::*;
  import coh_bus_pkg::*;

  typedef enum {
    ev_none, ev_miss, ev_own_gets, ev_fill_data, ev_fill_excl,
    ev_other_gets, ev_other_getm, ev_own_resp, ev_inval
  } event_e;

  localparam int timeout_cycles = 20;

  logic                 clk = 1'b0;
  logic                 rst;
  cpu_req_t             cpu;
  way_hits_t            hits;
  logic                 dfp_resp;
  logic [line_bits-1:0] dfp_rdata;
  logic [line_bits-1:0] bus_rdata;
  req_msg_t             req_bus_msg;
  req_msg_t             req_bus_tx;
  logic                 req_bus_gnt;
  logic                 req_bus_req;
  logic                 req_bus_busy;
  resp_msg_t            resp_bus_msg;
  resp_msg_t            resp_bus_tx;
  logic                 resp_bus_gnt;
  logic                 resp_bus_req;
  logic                 invalidate_req;
  logic                 invalidate_resp;

  // Model of the line states and the expected fill data
  line_state_e          model_q [sets][ways];
  logic [line_bits-1:0] exp_rdata;
  logic [3:0]           watch;
  string                test_name;
  int                   test_errors;
  int                   passed_tests;
  int                   failed_tests;

  always #20 clk = ~clk;

  assign watch = {invalidate_resp, resp_bus_req, req_bus_busy, req_bus_req};

  icache_coherence #(
    .cache_id (1)
  ) i_icache_coherence (.*);

  // Next line state for one event
  function automatic line_state_e ref_next(line_state_e cur, event_e ev);
    case (ev)
      ev_miss:       return (cur == st_i) ? st_isad : cur;
      ev_own_gets:   return (cur == st_isad) ? st_isd : cur;
      ev_fill_data:  return (cur == st_isd) ? st_s : cur;
      ev_fill_excl:  return (cur == st_isd) ? st_e : cur;
      ev_other_gets: return (cur == st_e) ? st_srd : cur;
      ev_other_getm: return (cur == st_s) ? st_i : ((cur == st_e) ? st_ird : cur);
      ev_own_resp:   return (cur == st_srd) ? st_s : ((cur == st_ird) ? st_i : cur);
      ev_inval:      return st_i;
      default:       return cur;
    endcase
  endfunction

  // Reads answer at once only from S or E
  function automatic logic ref_dfp_resp(cpu_req_t c, way_hits_t h);
    logic hit;
    hit = 1'b0;
    for (int w = 0; w < ways; w++) begin
      if (h.cache_hit[w] && (model_q[c.addr[index_bits-1:0]][w] inside {st_s, st_e})) begin
        hit = 1'b1;
      end
    end
    return c.read && hit;
  endfunction

  function automatic req_msg_t ref_req(logic [addr_bits-1:0] addr);
    return '{valid: 1'b1, source: cache_id_t'(1), addr: addr, bus_op: op_gets};
  endfunction

  // Snoop data always goes out as plain data, memory takes it only for GetS
  function automatic resp_msg_t ref_snoop_resp(int way, cache_id_t dest, bus_op_e op,
                                               logic [addr_bits-1:0] addr,
                                               logic [line_bits-1:0] data);
    return '{valid: 1'b1, source: cache_id_t'(1), way: way_idx_t'(way), destination: dest,
             memory_flag: (op == op_gets), addr: addr, data: data, kind: rk_data};
  endfunction

  function automatic logic [line_bits-1:0] rand_line();
    logic [line_bits-1:0] d;
    for (int i = 0; i < line_bits / 32; i++) begin
      d[i*32 +: 32] = $urandom();
    end
    return d;
  endfunction

  // Random tag bits above a chosen set index
  function automatic logic [addr_bits-1:0] rand_addr(int index);
    logic [addr_bits-1:0] a;
    a = $urandom();
    a[index_bits-1:0] = index_bits'(index);
    return a;
  endfunction

  task automatic check(string what, logic [319:0] expected, logic [319:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  // Compare process for the combinational CPU-side outputs
  always @(negedge clk) begin
    if (!rst) begin
      check("dfp_resp", ref_dfp_resp(cpu, hits), dfp_resp);
      check("dfp_rdata", exp_rdata, dfp_rdata);
    end
  end

  task automatic idle();
    cpu            = '0;
    hits           = '0;
    req_bus_msg    = '0;
    resp_bus_msg   = '0;
    req_bus_gnt    = 1'b0;
    invalidate_req = 1'b0;
    exp_rdata      = '0;
  endtask

  // Clock edge, model follows the DUT, then inputs change 2 ns later
  task automatic next_cycle(event_e ev, logic [addr_bits-1:0] addr, int way);
    @(posedge clk);
    if (ev != ev_none) begin
      model_q[addr[index_bits-1:0]][way] = ref_next(model_q[addr[index_bits-1:0]][way], ev);
    end
    #2;
  endtask

  task automatic wait_level(string what, int sel, logic level, output int cycles);
    cycles = 0;
    for (int n = 1; n <= timeout_cycles && cycles == 0; n++) begin
      @(negedge clk);
      if (watch[sel] === level) begin
        cycles = n;
      end
    end
    if (cycles == 0) begin
      $display("Timeout in %s: %s did not reach %0b in %0d cycles",
               test_name, what, level, timeout_cycles);
      test_errors++;
    end
  endtask

  task automatic start_test(string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      passed_tests++;
      $display("%s: ok", test_name);
    end else begin
      failed_tests++;
      $display("%s: %0d errors", test_name, test_errors);
    end
  endtask

  // Load miss on a free victim way, held request, then grant
  task automatic request_line(logic [addr_bits-1:0] addr, int way);
    cpu        = '{read: 1'b1, addr: addr};
    hits.evict = way_vec_t'(1 << way);
    @(negedge clk);
    check("req_bus_req in miss cycle", 0, req_bus_req);
    next_cycle(ev_miss, addr, way);
    idle();
    @(negedge clk);
    check("req_bus_tx after miss", ref_req(addr), req_bus_tx);
    repeat ($urandom_range(1, 3)) begin
      next_cycle(ev_none, addr, way);
      @(negedge clk);
      check("req_bus_tx without grant", ref_req(addr), req_bus_tx);
    end
    next_cycle(ev_none, addr, way);
    req_bus_gnt = 1'b1;
    @(negedge clk);
    check("req_bus_req in grant cycle", 1, req_bus_req);
    next_cycle(ev_none, addr, way);
    req_bus_gnt = 1'b0;
    @(negedge clk);
    check("req_bus_req after grant", 0, req_bus_req);
    next_cycle(ev_none, addr, way);
  endtask

  // Own GetS seen on the bus, then the fill from memory
  task automatic fill_response(logic [addr_bits-1:0] addr, int way, resp_kind_e kind);
    logic [line_bits-1:0] data;
    int                   n;
    data        = rand_line();
    req_bus_msg = ref_req(addr);
    hits.evict  = way_vec_t'(1 << way);
    @(negedge clk);
    check("req_bus_busy before own GetS", 0, req_bus_busy);
    next_cycle(ev_own_gets, addr, way);
    idle();
    wait_level("req_bus_busy", 1, 1'b1, n);
    check("req_bus_busy rise cycles", 1, n);
    repeat ($urandom_range(1, 3)) next_cycle(ev_none, addr, way);
    resp_bus_msg = '{valid: 1'b1, source: cache_id_t'(num_cache), way: '0,
                     destination: cache_id_t'(1), memory_flag: 1'b0, addr: addr,
                     data: data, kind: kind};
    hits.evict   = way_vec_t'(1 << way);
    exp_rdata    = data;
    @(negedge clk);
    check("req_bus_busy during fill", 1, req_bus_busy);
    next_cycle((kind == rk_exclusive) ? ev_fill_excl : ev_fill_data, addr, way);
    idle();
    wait_level("req_bus_busy", 1, 1'b0, n);
    check("req_bus_busy fall cycles", 1, n);
    next_cycle(ev_none, addr, way);
  endtask

  task automatic hit_read(logic [addr_bits-1:0] addr, int way, logic expect_hit);
    cpu            = '{read: 1'b1, addr: addr};
    hits.cache_hit = way_vec_t'(1 << way);
    @(negedge clk);
    check("dfp_resp on hit read", expect_hit, dfp_resp);
    next_cycle(ev_none, addr, way);
    idle();
  endtask

  // Another cache asks for a line we hold in E
  task automatic snoop_exclusive(logic [addr_bits-1:0] addr, int way, cache_id_t other,
                                 bus_op_e op);
    logic [line_bits-1:0] data;
    int                   n;
    data         = rand_line();
    bus_rdata    = data;
    req_bus_msg  = '{valid: 1'b1, source: other, addr: addr, bus_op: op};
    hits.bus_hit = way_vec_t'(1 << way);
    next_cycle((op == op_gets) ? ev_other_gets : ev_other_getm, addr, way);
    idle();
    wait_level("resp_bus_req", 2, 1'b1, n);
    check("resp_bus_req rise cycles", 1, n);
    check("resp_bus_tx", ref_snoop_resp(way, other, op, addr, data), resp_bus_tx);
    next_cycle(ev_none, addr, way);
    // Fresh array data must not leak into the captured response
    bus_rdata    = rand_line();
    resp_bus_msg = ref_snoop_resp(way, other, op, addr, data);
    @(negedge clk);
    check("resp_bus_tx held", ref_snoop_resp(way, other, op, addr, data), resp_bus_tx);
    next_cycle(ev_own_resp, addr, way);
    idle();
    wait_level("resp_bus_req", 2, 1'b0, n);
    check("resp_bus_req fall cycles", 1, n);
    next_cycle(ev_none, addr, way);
  endtask

  initial begin
    logic [addr_bits-1:0] addr;
    int                   way;
    int                   n;
    void'($urandom(32));
    rst          = 1'b1;
    bus_rdata    = '0;
    resp_bus_gnt = 1'b0;
    idle();
    for (int s = 0; s < sets; s++) begin
      for (int w = 0; w < ways; w++) begin
        model_q[s][w] = st_i;
      end
    end
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    way  = $urandom_range(0, ways - 1);
    addr = rand_addr(1);
    start_test("read_miss_gets");
    request_line(addr, way);
    end_test();

    start_test("own_gets_fill_exclusive");
    fill_response(addr, way, rk_exclusive);
    hit_read(addr, way, 1'b1);
    end_test();

    start_test("other_getm_on_s");
    way  = $urandom_range(0, ways - 1);
    addr = rand_addr(2);
    request_line(addr, way);
    fill_response(addr, way, rk_data);
    hit_read(addr, way, 1'b1);
    req_bus_msg  = '{valid: 1'b1, source: cache_id_t'(2), addr: addr, bus_op: op_getm};
    hits.bus_hit = way_vec_t'(1 << way);
    next_cycle(ev_other_getm, addr, way);
    idle();
    hit_read(addr, way, 1'b0);
    end_test();

    start_test("other_gets_on_e");
    way  = $urandom_range(0, ways - 1);
    addr = rand_addr(3);
    request_line(addr, way);
    fill_response(addr, way, rk_exclusive);
    snoop_exclusive(addr, way, cache_id_t'(3), op_gets);
    hit_read(addr, way, 1'b1);
    end_test();

    start_test("other_getm_on_e");
    way  = $urandom_range(0, ways - 1);
    addr = rand_addr(4);
    request_line(addr, way);
    fill_response(addr, way, rk_exclusive);
    snoop_exclusive(addr, way, cache_id_t'(2), op_getm);
    hit_read(addr, way, 1'b0);
    end_test();

    start_test("back_invalidate");
    way  = $urandom_range(0, ways - 1);
    addr = rand_addr(5);
    request_line(addr, way);
    fill_response(addr, way, rk_data);
    hit_read(addr, way, 1'b1);
    cpu            = '{read: 1'b0, addr: addr};
    hits.cache_hit = way_vec_t'(1 << way);
    invalidate_req = 1'b1;
    next_cycle(ev_inval, addr, way);
    wait_level("invalidate_resp", 3, 1'b1, n);
    check("invalidate_resp rise cycles", 1, n);
    // Request still held for a second cycle
    next_cycle(ev_none, addr, way);
    idle();
    @(negedge clk);
    check("invalidate_resp second cycle", 0, invalidate_resp);
    next_cycle(ev_none, addr, way);
    hit_read(addr, way, 1'b0);
    end_test();

    $display("Tests ok: %0d, with errors: %0d", passed_tests, failed_tests);
    if (failed_tests == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Overall cycle limit
  initial begin
    for (int c = 0; c < 2000; c++) begin
      @(posedge clk);
    end
    $display("Simulation ran past its cycle limit");
    $display("sim failed");
    $finish;
  end

endmodule

//--- tb.f
hw/cache_geom_pkg.sv
hw/coh_bus_pkg.sv
hw/miss_requester.sv
hw/line_state_store.sv
hw/snoop_controller.sv
hw/icache_coherence.sv
tb/icache_coherence_asserts.sv
tb/tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$log"; then
  exit 1
fi
exit 0
